// ==== Bender.yml ====
package:
  name: acc_unit

sources:
  - files:
      - src/acc_pkg.sv
      - src/cmd_queue.sv
      - src/instr_decode.sv
      - src/acc_sequencer.sv
      - src/acc_datapath.sv
      - src/eae_muldiv.sv
      - src/acc_top.sv
  - target: test
    files:
      - tests/acc_sva.sv
      - tests/acc_tb.sv

// ==== all.f ====
src/acc_pkg.sv
src/cmd_queue.sv
src/instr_decode.sv
src/acc_sequencer.sv
src/acc_datapath.sv
src/eae_muldiv.sv
src/acc_top.sv
tests/acc_sva.sv
tests/acc_tb.sv

// ==== src/acc_datapath.sv ====
`default_nettype none

module acc_datapath
    import acc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  phase_e  phase,
    input  acc_op_e op,
    input  word_t   cur_instr,
    input  word_t   cur_operand,
    input  logic    eae_done,
    input  word_t   eae_ac,
    input  word_t   eae_mq,
    input  logic    eae_link,
    output word_t   ac,
    output logic    link,
    output word_t   mq
);

    word_t              ac_clr;
    logic               link_clr;
    logic [0:WORD_BITS] tad_sum;                   // bit 0 is the carry out
    logic [0:WORD_BITS] inc_sum;

    // cla is bit 4 in both group 1 and group 3
    assign ac_clr   = cur_instr[4] ? '0 : ac;
    assign link_clr = cur_instr[5] ? 1'b0 : link;  // cll, group 1 only
    assign tad_sum  = {1'b0, ac} + {1'b0, cur_operand};
    assign inc_sum  = {link, ac} + {{WORD_BITS{1'b0}}, 1'b1};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ac   <= '0;
            link <= 1'b0;
            mq   <= '0;
        end
        else if (eae_done)
        begin
            ac   <= eae_ac;
            link <= eae_link;
            mq   <= eae_mq;
        end
        else
        begin
            case (phase)
                PH_1:
                case (op)
                    OP_OPR1:
                    begin
                        ac   <= cur_instr[6] ? ~ac_clr : ac_clr;    // cma
                        link <= cur_instr[7] ? ~link_clr : link_clr; // cml
                    end
                    OP_MQ:
                    begin
                        // mqa ors mq in, mql moves ac out; both together swap
                        ac <= (cur_instr[5] ? mq : '0) | (cur_instr[7] ? '0 : ac_clr);
                        if (cur_instr[7])
                            mq <= ac_clr;
                    end
                    OP_AND: ac <= ac & cur_operand;
                    OP_TAD:
                    begin
                        ac   <= tad_sum[1:WORD_BITS];
                        link <= link ^ tad_sum[0];
                    end
                    OP_DCA: ac <= '0;              // store already done outside
                    default: ;
                endcase
                PH_2:
                if ((op == OP_OPR1) && cur_instr[WORD_BITS-1])
                    {link, ac} <= inc_sum;         // iac
                PH_3:
                if (op == OP_OPR1)
                begin
                    case (cur_instr[8:10])
                        3'd1: ac <= {ac[6:11], ac[0:5]};                  // bsw
                        3'd2: {link, ac} <= {ac, link};                   // ral
                        3'd3: {link, ac} <= {ac[1:11], link, ac[0]};      // rtl
                        3'd4: {link, ac} <= {ac[11], link, ac[0:10]};     // rar
                        3'd5: {link, ac} <= {ac[10:11], link, ac[0:9]};   // rtr
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/acc_pkg.sv ====
`default_nettype none

package acc_pkg;

    localparam int WORD_BITS = 12;
    localparam int CMD_DEPTH = 2;                  // queue entries and initial credits
    localparam int QPTR_BITS = $clog2(CMD_DEPTH);
    localparam int CNT_BITS  = 4;
    localparam int EAE_STEPS = 12;                 // one step per mq bit

    typedef logic [0:WORD_BITS-1] word_t;          // bit 0 is the msb, pdp-8 numbering

    localparam word_t EAE_MASK = 12'o7417;         // ignores cla, mqa, sca, mql
    localparam word_t EAE_MUL  = 12'o7405;
    localparam word_t EAE_DIV  = 12'o7407;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_AND,
        OP_TAD,
        OP_DCA,
        OP_OPR1,                                   // group 1 operate
        OP_MQ,                                     // group 3 without arithmetic
        OP_MUL,
        OP_DIV
    } acc_op_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_1,                                      // clear/complement, mq moves, memory ops
        PH_2,                                      // increment
        PH_3                                       // rotates
    } phase_e;

endpackage

`default_nettype wire

// ==== src/acc_sequencer.sv ====
`default_nettype none

module acc_sequencer
    import acc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    q_valid,
    input  word_t   q_instr,
    input  word_t   q_operand,
    input  acc_op_e op,
    input  logic    eae_done,
    output logic    pop,
    output word_t   cur_instr,
    output word_t   cur_operand,
    output phase_e  phase,
    output logic    eae_start,
    output logic    done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PH1,
        S_PH2,
        S_PH3,
        S_WAIT,                                    // mul/div running
        S_FIN
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_next;
    logic       is_arith;

    assign is_arith  = (op == OP_MUL) || (op == OP_DIV);
    assign pop       = (state == S_IDLE) && q_valid;
    assign eae_start = (state == S_PH1) && is_arith;
    assign done      = (state == S_FIN);

    always_comb
    begin
        case (state)
            S_PH1:   phase = PH_1;
            S_PH2:   phase = PH_2;
            S_PH3:   phase = PH_3;
            default: phase = PH_IDLE;
        endcase
    end

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:  if (q_valid) state_next = S_PH1;
            S_PH1:   state_next = is_arith ? S_WAIT : S_PH2;
            S_PH2:   state_next = S_PH3;
            S_PH3:   state_next = S_FIN;
            S_WAIT:  if (eae_done) state_next = S_FIN;
            S_FIN:   state_next = S_IDLE;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            cur_instr   <= q_instr;                // held for the whole command
            cur_operand <= q_operand;
        end
    end

endmodule

`default_nettype wire

// ==== src/acc_top.sv ====
`default_nettype none

module acc_top
    import acc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_valid,
    input  word_t cmd_instr,
    input  word_t cmd_operand,
    output logic  credit,
    output logic  done,
    output word_t ac,
    output logic  link,
    output word_t mq
);

    logic    q_valid;
    word_t   q_instr;
    word_t   q_operand;
    logic    pop;
    word_t   cur_instr;
    word_t   cur_operand;
    acc_op_e op;
    phase_e  phase;
    logic    eae_start;
    logic    eae_done;
    word_t   eae_ac;
    word_t   eae_mq;
    logic    eae_link;

    cmd_queue i_queue (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_instr   (cmd_instr),
        .cmd_operand (cmd_operand),
        .pop         (pop),
        .q_valid     (q_valid),
        .q_instr     (q_instr),
        .q_operand   (q_operand),
        .credit      (credit)
    );

    instr_decode i_decode (
        .instr (cur_instr),
        .op    (op)
    );

    acc_sequencer i_seq (
        .clk         (clk),
        .reset       (reset),
        .q_valid     (q_valid),
        .q_instr     (q_instr),
        .q_operand   (q_operand),
        .op          (op),
        .eae_done    (eae_done),
        .pop         (pop),
        .cur_instr   (cur_instr),
        .cur_operand (cur_operand),
        .phase       (phase),
        .eae_start   (eae_start),
        .done        (done)
    );

    acc_datapath i_dp (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .op          (op),
        .cur_instr   (cur_instr),
        .cur_operand (cur_operand),
        .eae_done    (eae_done),
        .eae_ac      (eae_ac),
        .eae_mq      (eae_mq),
        .eae_link    (eae_link),
        .ac          (ac),
        .link        (link),
        .mq          (mq)
    );

    eae_muldiv i_eae (
        .clk         (clk),
        .reset       (reset),
        .eae_start   (eae_start),
        .op          (op),
        .ac          (ac),
        .mq          (mq),
        .cur_operand (cur_operand),
        .eae_done    (eae_done),
        .eae_ac      (eae_ac),
        .eae_mq      (eae_mq),
        .eae_link    (eae_link)
    );

endmodule

`default_nettype wire

// ==== src/cmd_queue.sv ====
`default_nettype none

module cmd_queue
    import acc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_valid,
    input  word_t cmd_instr,
    input  word_t cmd_operand,
    input  logic  pop,
    output logic  q_valid,
    output word_t q_instr,
    output word_t q_operand,
    output logic  credit
);

    word_t                instr_mem   [CMD_DEPTH];
    word_t                operand_mem [CMD_DEPTH];
    logic [QPTR_BITS-1:0] wr_ptr;
    logic [QPTR_BITS-1:0] rd_ptr;
    logic [QPTR_BITS:0]   count;
    logic                 full;
    logic                 push;
    logic                 take;

    function automatic logic [QPTR_BITS-1:0] next_ptr(input logic [QPTR_BITS-1:0] ptr);
        if (ptr == QPTR_BITS'(CMD_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full      = (count == (QPTR_BITS + 1)'(CMD_DEPTH));
    assign q_valid   = (count != '0);
    assign take      = pop && q_valid;
    assign push      = cmd_valid && (!full || take);  // slot frees in the same cycle
    assign q_instr   = instr_mem[rd_ptr];
    assign q_operand = operand_mem[rd_ptr];
    assign credit    = take;                           // one credit per leaving entry

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            instr_mem[wr_ptr]   <= cmd_instr;
            operand_mem[wr_ptr] <= cmd_operand;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (take)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/eae_muldiv.sv ====
`default_nettype none

module eae_muldiv
    import acc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    eae_start,
    input  acc_op_e op,
    input  word_t   ac,
    input  word_t   mq,
    input  word_t   cur_operand,
    output logic    eae_done,
    output word_t   eae_ac,
    output word_t   eae_mq,
    output logic    eae_link
);

    logic [CNT_BITS-1:0] cnt;                      // remaining steps
    logic                busy;
    logic                is_div;
    logic                div_ovf;
    word_t               opnd;
    logic [0:WORD_BITS]  mul_sum;                  // carry plus high half
    logic [0:WORD_BITS]  rem_sh;                   // remainder with next dividend bit
    logic [0:WORD_BITS]  rem_sub;
    logic                rem_ge;

    assign div_ovf = (op == OP_DIV) && (ac >= cur_operand);
    assign mul_sum = eae_mq[WORD_BITS-1] ? ({1'b0, eae_ac} + {1'b0, opnd}) : {1'b0, eae_ac};
    assign rem_sh  = {eae_ac, eae_mq[0]};
    assign rem_ge  = (rem_sh >= {1'b0, opnd});
    assign rem_sub = rem_sh - {1'b0, opnd};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            is_div   <= 1'b0;
            cnt      <= '0;
            eae_done <= 1'b0;
        end
        else
        begin
            eae_done <= 1'b0;
            if (eae_start)
            begin
                is_div <= (op == OP_DIV);
                if (div_ovf)
                    eae_done <= 1'b1;              // quotient would not fit
                else
                begin
                    busy <= 1'b1;
                    cnt  <= CNT_BITS'(EAE_STEPS);
                end
            end
            else if (busy)
            begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_BITS'(1))
                begin
                    busy     <= 1'b0;
                    eae_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (eae_start)
        begin
            opnd     <= cur_operand;
            eae_ac   <= ac;
            eae_link <= div_ovf;                   // mul always clears link
            eae_mq   <= div_ovf ? {mq[1:WORD_BITS-1], 1'b1} : mq;
        end
        else if (busy)
        begin
            if (is_div)
            begin
                eae_ac <= rem_ge ? rem_sub[1:WORD_BITS] : rem_sh[1:WORD_BITS];
                eae_mq <= {eae_mq[1:WORD_BITS-1], rem_ge};
            end
            else
                {eae_ac, eae_mq} <= {mul_sum, eae_mq[0:WORD_BITS-2]};  // add then shift right
        end
    end

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
`default_nettype none

module instr_decode
    import acc_pkg::*;
(
    input  word_t   instr,
    output acc_op_e op
);

    logic is_opr;
    logic is_grp3;
    logic is_mul;
    logic is_div;

    assign is_opr  = (instr[0:2] == 3'o7);
    assign is_grp3 = is_opr && instr[3] && instr[WORD_BITS-1];  // 1111 ... 1
    assign is_mul  = ((instr & EAE_MASK) == EAE_MUL);
    assign is_div  = ((instr & EAE_MASK) == EAE_DIV);

    always_comb
    begin
        op = OP_NOP;
        case (instr[0:2])
            3'o0: op = OP_AND;
            3'o1: op = OP_TAD;
            3'o3: op = OP_DCA;
            3'o7:
            begin
                if (!instr[3])
                    op = OP_OPR1;
                else if (is_grp3 && is_mul)
                    op = OP_MUL;
                else if (is_grp3 && is_div)
                    op = OP_DIV;
                else if (is_grp3)
                    op = OP_MQ;                    // group 2 stays a nop
            end
            default: op = OP_NOP;                  // isz, jms, jmp, iot
        endcase
    end

endmodule

`default_nettype wire

// ==== tests/acc_sva.sv ====
`default_nettype none

module acc_sva
    import acc_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic cmd_valid,
    input logic q_full,
    input logic credit,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ns;

    int fails = 0;                                 // failed assertions so far

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else
        begin
            $error("done high for two cycles in a row");
            fails++;
        end

    // sender may only write with a credit in hand
    no_overrun: assert property (@(posedge clk) disable iff (reset) !(cmd_valid && q_full))
        else
        begin
            $error("command written while the queue is full");
            fails++;
        end

    quiet_reset: assert property (@(posedge clk) reset |=> !credit && !done)
        else
        begin
            $error("credit or done high after a reset cycle");
            fails++;
        end

endmodule

bind acc_top acc_sva i_sva (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .q_full    (i_queue.full),
    .credit    (credit),
    .done      (done)
);

`default_nettype wire

// ==== tests/acc_tb.sv ====
`default_nettype none

module acc_tb
    import acc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int SETUP_CMDS  = 5;                // commands to load ac, link, mq
    localparam int TOTAL_CMDS  = (40 + 30 + 8 + 20 + 20) * (SETUP_CMDS + 1) + 30;
    localparam int WATCHDOG_NS = TOTAL_CMDS * 20 * 100 + 50 * 100;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    logic [11:0] cmd_instr;
    logic [11:0] cmd_operand;
    logic        credit;
    logic        done;
    logic [11:0] ac;
    logic        link;
    logic [11:0] mq;

    logic [31:0] rng;
    logic [24:0] model;                            // link, ac, mq after all sent commands
    logic [24:0] exp_q [$];
    string       name_q [$];
    logic [24:0] exp_st;
    logic [24:0] got_st;
    string       exp_name;
    int          credits;
    int          returned;
    int          sent;
    int          errors;
    int          test_err0;
    int          test_sent0;

    acc_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_instr   (cmd_instr),
        .cmd_operand (cmd_operand),
        .credit      (credit),
        .done        (done),
        .ac          (ac),
        .link        (link),
        .mq          (mq)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [11:0] rand_word();
        rng = xorshift32(rng);
        return rng[11:0];
    endfunction

    // expected {link, ac, mq} after one command
    function automatic logic [24:0] ref_step(input logic [24:0] st, input logic [11:0] instr,
                                             input logic [11:0] opnd);
        logic        l;
        logic [11:0] a;
        logic [11:0] m;
        logic [11:0] t;
        logic [12:0] v;
        logic [23:0] wide;
        l = st[24];
        a = st[23:12];
        m = st[11:0];
        case (instr[11:9])
            3'o0: a = a & opnd;
            3'o1:
            begin
                v = {1'b0, a} + {1'b0, opnd};
                a = v[11:0];
                l = l ^ v[12];                     // carry complements link
            end
            3'o3: a = 12'o0000;
            3'o7:
            begin
                if (!instr[8])
                begin
                    if (instr[7])
                        a = 12'o0000;
                    if (instr[6])
                        l = 1'b0;
                    if (instr[5])
                        a = ~a;
                    if (instr[4])
                        l = ~l;
                    v = {l, a};
                    if (instr[0])
                        v = v + 13'd1;
                    case (instr[3:1])
                        3'd1: v = {v[12], v[5:0], v[11:6]};  // byte swap
                        3'd2: v = {v[11:0], v[12]};
                        3'd3: v = {v[10:0], v[12:11]};
                        3'd4: v = {v[0], v[12:1]};
                        3'd5: v = {v[1:0], v[12:2]};
                        default: ;
                    endcase
                    l = v[12];
                    a = v[11:0];
                end
                else if (instr[0] && ((instr & 12'o7417) == 12'o7405))
                begin
                    wide = {12'd0, m} * {12'd0, opnd} + {12'd0, a};
                    a = wide[23:12];
                    m = wide[11:0];
                    l = 1'b0;
                end
                else if (instr[0] && ((instr & 12'o7417) == 12'o7407))
                begin
                    if (a >= opnd)
                    begin
                        l = 1'b1;                  // divide overflow
                        m = {m[10:0], 1'b1};
                    end
                    else
                    begin
                        wide = {a, m};
                        t = 12'(wide / {12'd0, opnd});
                        a = 12'(wide % {12'd0, opnd});
                        m = t;
                        l = 1'b0;
                    end
                end
                else if (instr[0])
                begin
                    if (instr[7])
                        a = 12'o0000;              // cla comes first
                    case ({instr[6], instr[4]})
                        2'b11:
                        begin
                            t = a;
                            a = m;
                            m = t;
                        end
                        2'b10: a = a | m;
                        2'b01:
                        begin
                            m = a;
                            a = 12'o0000;
                        end
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
        return {l, a, m};
    endfunction

    task automatic send_cmd(input logic [11:0] instr, input logic [11:0] opnd,
                            input string name);
        while (credits == 0)
            @(negedge clk);
        cmd_valid   = 1'b1;
        cmd_instr   = instr;
        cmd_operand = opnd;
        credits--;
        sent++;
        model = ref_step(model, instr, opnd);
        exp_q.push_back(model);
        name_q.push_back(name);
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic load_state(input logic [11:0] a, input logic l, input logic [11:0] m,
                              input string name);
        send_cmd(12'o7300, 12'o0000, name);        // cla cll
        send_cmd(12'o1000, m, name);
        send_cmd(12'o7421, 12'o0000, name);        // mql
        send_cmd(l ? 12'o7120 : 12'o7100, 12'o0000, name);
        send_cmd(12'o1000, a, name);
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
    endtask

    task automatic begin_test();
        test_err0  = errors;
        test_sent0 = sent;
    endtask

    task automatic end_test(input string name);
        drain();
        $display("test %-7s %4d commands, %0d errors", name, sent - test_sent0,
                 errors - test_err0);
    endtask

    // credit return and result comparison
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (credit)
            begin
                credits++;
                returned++;
            end
            assert (credits >= 0 && credits <= CMD_DEPTH)
            else
            begin
                $display("Error: sender credit count %0d is out of range", credits);
                errors++;
            end
            if (done)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    $display("Error: done pulse with no command outstanding");
                    errors++;
                end
                if (exp_q.size() != 0)
                begin
                    exp_st   = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    got_st   = {link, ac, mq};
                    assert (got_st == exp_st)
                    else
                    begin
                        $display("Mismatch %s: expected link=%0d ac=%04o mq=%04o, %s%0d %s%04o %s%04o",
                                 exp_name, exp_st[24], exp_st[23:12], exp_st[11:0],
                                 "actual link=", got_st[24], "ac=", got_st[23:12],
                                 "mq=", got_st[11:0]);
                        errors++;
                    end
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Error: timeout after %0d ns, commands still outstanding", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic [11:0] a;
        logic [11:0] m;
        logic [11:0] op;
        logic [11:0] r;
        logic [11:0] instr;
        logic        l;
        int          kind;
        rng         = 32'hd4da_b26e;
        model       = '0;
        credits     = CMD_DEPTH;
        returned    = 0;
        sent        = 0;
        errors      = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_instr   = '0;
        cmd_operand = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test();
        for (int i = 0; i < 40; i++)
        begin
            r = rand_word();
            load_state(rand_word(), r[0], rand_word(), "group1");
            r = rand_word();
            send_cmd(12'o7000 | {4'd0, r[7:0]}, rand_word(), "group1");
        end
        end_test("group1");

        begin_test();
        for (int i = 0; i < 30; i++)
        begin
            a  = rand_word();
            m  = rand_word();
            op = rand_word();
            r  = rand_word();
            if (i % 6 == 1)
            begin
                a  = a | 12'o4000;                 // tad with a certain carry
                op = op | 12'o4000;
            end
            kind = (i % 3 == 2) ? 3 : i % 3;
            load_state(a, r[11], m, "memory");
            send_cmd({kind[2:0], r[8:0]}, op, "memory");
        end
        end_test("memory");

        begin_test();
        for (int c = 0; c < 8; c++)
        begin
            r = rand_word();
            load_state(rand_word(), r[0], rand_word(), "mq");
            instr = 12'o7401;
            if (c[2])
                instr = instr | 12'o0200;          // cla
            if (c[1])
                instr = instr | 12'o0100;          // mqa
            if (c[0])
                instr = instr | 12'o0020;          // mql
            send_cmd(instr, 12'o0000, "mq");
        end
        end_test("mq");

        begin_test();
        for (int i = 0; i < 20; i++)
        begin
            r = rand_word();
            load_state(rand_word(), r[0], rand_word(), "mul");
            send_cmd(12'o7405, rand_word(), "mul");
        end
        end_test("mul");

        begin_test();
        for (int i = 0; i < 20; i++)
        begin
            if (i % 4 == 0)
            begin
                op = rand_word() & 12'o3777;       // forced overflow
                a  = rand_word() | 12'o4000;
            end
            else
            begin
                op = rand_word() | 12'o4000;
                a  = rand_word() & 12'o3777;
            end
            m = rand_word();
            l = m[5];
            load_state(a, l, m, "div");
            send_cmd(12'o7407, op, "div");
        end
        end_test("div");

        begin_test();
        for (int i = 0; i < 30; i++)
        begin
            r    = rand_word();
            kind = r % 7;
            r    = rand_word();
            case (kind)
                0:       instr = 12'o7000 | {4'd0, r[7:0]};
                1:       instr = {3'o0, r[8:0]};
                2:       instr = {3'o1, r[8:0]};
                3:       instr = {3'o3, r[8:0]};
                4:       instr = 12'o7401 | (r & 12'o0320);
                5:       instr = 12'o7405;
                default: instr = 12'o7407;
            endcase
            send_cmd(instr, rand_word(), "burst");
        end
        drain();
        assert (returned == sent)
        else
        begin
            $display("Error: %0d credits returned for %0d commands sent", returned, sent);
            errors++;
        end
        end_test("burst");

        errors = errors + i_dut.i_sva.fails;       // bound checker failures
        $display("%0d commands, %0d errors", sent, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
